/* sources.f */
hdl/framer_pkg.sv
hdl/header_builder.sv
hdl/trailer_builder.sv
hdl/stream_splicer.sv
hdl/packet_framer_top.sv
testbench/clock_gen.sv
testbench/packet_framer_tb.sv

/* Makefile */
# Verilator build and run of the packet framer testbench

TOP := packet_framer_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check sim.log for the pass message"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f sources.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* testbench/packet_framer_tb.sv */
// ####################################################################
// Packet framer testbench with table-driven frames checked against
// a reference model
// ####################################################################
`timescale 1ns/1ps
module packet_framer_tb;

    localparam int NUM_CASES  = 8;
    localparam int MAX_LEN    = 16;
    localparam int WAIT_LIMIT = 400;

    typedef struct packed {
        logic [7:0]  tag;
        int          len;
        logic [31:0] data_seed;
        int          bp_pct;
        int          trig_delay;
    } frame_case_t;

    logic                     clock;
    logic                     rst_n;
    logic                     trigger = 1'b0;
    logic                     desc_strobe = 1'b0;
    framer_pkg::frame_desc_t  desc = '0;
    logic                     body_valid = 1'b0;
    framer_pkg::stream_beat_t body_beat = '0;
    logic                     out_ready = 1'b0;
    logic                     body_ready;
    logic                     out_valid;
    framer_pkg::stream_beat_t out_beat;

    frame_case_t              cases [NUM_CASES];
    logic [31:0]              words [NUM_CASES][MAX_LEN];
    framer_pkg::stream_beat_t exp_q [$];
    int                       span_q [$];
    integer                   seed = 91;
    int                       bp_pct = 0;
    logic [31:0]              exp_seq = '0;
    logic                     gate_check = 1'b0;
    int                       timed_out = 0;
    int                       errors = 0;
    int                       frames_seen = 0;
    int                       cycle_cnt = 0;
    int                       start_cycle = 0;
    int                       beat_idx = 0;
    logic                     hold_check = 1'b0;
    logic                     reset_checked = 1'b0;
    framer_pkg::stream_beat_t held_beat = '0;

    clock_gen clock_gen_inst (
        .clock (clock),
        .rst_n (rst_n)
    );

    packet_framer_top packet_framer_top_inst (
        .clock       (clock),
        .rst_n       (rst_n),
        .trigger     (trigger),
        .desc_strobe (desc_strobe),
        .desc        (desc),
        .body_valid  (body_valid),
        .body_beat   (body_beat),
        .out_ready   (out_ready),
        .body_ready  (body_ready),
        .out_valid   (out_valid),
        .out_beat    (out_beat)
    );

    function automatic framer_pkg::stream_beat_t make_beat(input logic [31:0] data,
                                                          input logic last);
        framer_pkg::stream_beat_t beat;
        beat.data = data;
        beat.last = last;
        return beat;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic finish_run();
        if (frames_seen != NUM_CASES)
            $display("Only %0d of %0d frames reached the output", frames_seen, NUM_CASES);
        $display("Summary: %0d check errors, %0d timeouts, %0d frames",
                 errors, timed_out, frames_seen);
        if (errors == 0 && timed_out == 0 && frames_seen == NUM_CASES) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        timed_out++;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && timed_out == 0) begin
            @(posedge clock);
            waited++;
            if (waited > WAIT_LIMIT)
                report_timeout("the expected beats to leave the output");
        end
    endtask

    task automatic wait_body_ready();
        int waited;
        waited = 0;
        @(negedge clock);
        while (!body_ready && timed_out == 0) begin
            waited++;
            if (waited > WAIT_LIMIT)
                report_timeout("body_ready on a payload beat");
            @(negedge clock);
        end
        @(posedge clock);
    endtask

    task automatic run_case(input int c);
        frame_case_t tc;
        logic [31:0] sum;
        int          i;
        tc  = cases[c];
        sum = '0;
        if (tc.trig_delay != 0) begin
            // Drain the pipeline before holding the trigger low
            wait_drain();
            @(posedge clock);
            trigger <= 1'b0;
            @(posedge clock);
        end
        @(posedge clock);
        bp_pct      <= tc.bp_pct;
        desc_strobe <= 1'b1;
        desc        <= '{tag: tc.tag, length: 16'(tc.len)};
        if (tc.trig_delay == 0)
            trigger <= 1'b1;
        else
            gate_check = 1'b1;
        exp_q.push_back(make_beat({framer_pkg::HEADER_MAGIC, tc.tag, 16'(tc.len)}, 1'b0));
        exp_q.push_back(make_beat(exp_seq, 1'b0));
        for (i = 0; i < tc.len; i++) begin
            sum = sum + words[c][i];
            exp_q.push_back(make_beat(words[c][i], 1'b0));
        end
        exp_q.push_back(make_beat(sum, 1'b1));
        // Header, payload and trailer back to back when never stalled
        span_q.push_back(tc.bp_pct == 0 ? tc.len + 3 : 0);
        exp_seq = exp_seq + 32'd1;
        @(posedge clock);
        desc_strobe <= 1'b0;
        if (tc.trig_delay != 0) begin
            repeat (tc.trig_delay) @(posedge clock);
            trigger <= 1'b1;
            gate_check = 1'b0;
        end
        for (i = 0; i < tc.len && timed_out == 0; i++) begin
            body_valid <= 1'b1;
            body_beat  <= make_beat(words[c][i], i == tc.len - 1);
            wait_body_ready();
        end
        body_valid <= 1'b0;
    endtask

    // Random output stalls at a per-frame density
    always @(posedge clock) begin
        int roll;
        roll = {$random(seed)} % 100;
        out_ready <= (roll >= bp_pct);
    end

    always @(negedge clock) begin
        framer_pkg::stream_beat_t exp_beat;
        int                       span;
        cycle_cnt++;
        if (!rst_n || !reset_checked) begin
            if (out_valid !== 1'b0 || body_ready !== 1'b0)
                report_mismatch("out_valid or body_ready high around reset");
            if (rst_n)
                reset_checked = 1'b1;
        end else begin
            if (gate_check && out_valid)
                report_mismatch("output active while trigger is low");
            if (hold_check && (!out_valid || out_beat !== held_beat))
                report_mismatch("output beat changed while stalled");
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    report_mismatch($sformatf("unexpected beat %h", out_beat.data));
                end else begin
                    exp_beat = exp_q.pop_front();
                    if (out_beat !== exp_beat)
                        report_mismatch($sformatf("beat %0d is %h/%b, expected %h/%b (%s)",
                            beat_idx, out_beat.data, out_beat.last, exp_beat.data,
                            exp_beat.last,
                            packet_framer_top_inst.stream_splicer_inst.state.name()));
                    if (beat_idx == 0)
                        start_cycle = cycle_cnt;
                    beat_idx++;
                    if (exp_beat.last) begin
                        span = span_q.pop_front();
                        if (span != 0 && cycle_cnt - start_cycle + 1 != span)
                            report_mismatch($sformatf("frame took %0d cycles, expected %0d",
                                cycle_cnt - start_cycle + 1, span));
                        beat_idx = 0;
                        frames_seen++;
                    end
                end
            end
            hold_check = out_valid && !out_ready;
            held_beat  = out_beat;
        end
    end

    initial begin
        int c;
        int i;
        int waited;
        cases[0] = '{8'h11,  4, 32'h0000_0000,  0, 0};
        cases[1] = '{8'h22,  1, 32'h5A5A_0001,  0, 0};
        cases[2] = '{8'h33,  7, 32'hFFFF_0000, 40, 0};
        cases[3] = '{8'h44,  5, 32'h1234_5678,  0, 3};
        cases[4] = '{8'h55,  1, 32'h0F0F_0F0F, 60, 0};
        cases[5] = '{8'h66, 12, 32'hDEAD_0000, 25, 5};
        cases[6] = '{8'h77,  3, 32'h0000_BEEF,  0, 0};
        cases[7] = '{8'h88, 16, 32'hC0DE_0000, 50, 2};
        for (c = 0; c < NUM_CASES; c++) begin
            for (i = 0; i < MAX_LEN; i++)
                words[c][i] = $random(seed) ^ cases[c].data_seed;
        end
        waited = 0;
        while (rst_n !== 1'b1 && timed_out == 0) begin
            @(posedge clock);
            waited++;
            if (waited > WAIT_LIMIT)
                report_timeout("reset release");
        end
        for (c = 0; c < NUM_CASES && timed_out == 0; c++)
            run_case(c);
        wait_drain();
        repeat (4) @(posedge clock);
        finish_run();
    end

endmodule

/* testbench/clock_gen.sv */
// ####################################################################
// Testbench clock of 8 ns period and a reset held low for 3 cycles
// ####################################################################
`timescale 1ns/1ps
module clock_gen (
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    initial begin
        rst_n <= 1'b0;
        repeat (3) @(posedge clock);
        rst_n <= 1'b1;
    end

endmodule

/* hdl/packet_framer_top.sv */
// ####################################################################
// Packet framer top: header, payload and checksum trailer on one stream
// ####################################################################
`timescale 1ns/1ps
module packet_framer_top (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      trigger,
    input  logic                      desc_strobe,
    input  framer_pkg::frame_desc_t   desc,
    input  logic                      body_valid,
    input  framer_pkg::stream_beat_t  body_beat,
    input  logic                      out_ready,
    output logic                      body_ready,
    output logic                      out_valid,
    output framer_pkg::stream_beat_t  out_beat
);

    logic                     hdr_valid;
    logic                     hdr_ready;
    framer_pkg::stream_beat_t hdr_beat;
    logic                     trl_valid;
    logic                     trl_ready;
    framer_pkg::stream_beat_t trl_beat;
    logic                     body_fire;

    // Accepted payload beats feed the checksum
    assign body_fire = body_valid && body_ready;

    header_builder header_builder_inst (
        .clock       (clock),
        .rst_n       (rst_n),
        .desc_strobe (desc_strobe),
        .desc        (desc),
        .hdr_ready   (hdr_ready),
        .hdr_valid   (hdr_valid),
        .hdr_beat    (hdr_beat)
    );

    trailer_builder trailer_builder_inst (
        .clock     (clock),
        .rst_n     (rst_n),
        .body_fire (body_fire),
        .body_beat (body_beat),
        .trl_ready (trl_ready),
        .trl_valid (trl_valid),
        .trl_beat  (trl_beat)
    );

    stream_splicer stream_splicer_inst (
        .clock      (clock),
        .rst_n      (rst_n),
        .trigger    (trigger),
        .hdr_valid  (hdr_valid),
        .hdr_beat   (hdr_beat),
        .body_valid (body_valid),
        .body_beat  (body_beat),
        .trl_valid  (trl_valid),
        .trl_beat   (trl_beat),
        .out_ready  (out_ready),
        .hdr_ready  (hdr_ready),
        .body_ready (body_ready),
        .trl_ready  (trl_ready),
        .out_valid  (out_valid),
        .out_beat   (out_beat)
    );

endmodule

/* hdl/stream_splicer.sv */
// ####################################################################
// Stream splicer: joins head, body and end streams into one output
// with a registered output stage and a one-beat skid buffer
// ####################################################################
`timescale 1ns/1ps
module stream_splicer (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      trigger,
    input  logic                      hdr_valid,
    input  framer_pkg::stream_beat_t  hdr_beat,
    input  logic                      body_valid,
    input  framer_pkg::stream_beat_t  body_beat,
    input  logic                      trl_valid,
    input  framer_pkg::stream_beat_t  trl_beat,
    input  logic                      out_ready,
    output logic                      hdr_ready,
    output logic                      body_ready,
    output logic                      trl_ready,
    output logic                      out_valid,
    output framer_pkg::stream_beat_t  out_beat
);

    framer_pkg::splice_state_e state;
    framer_pkg::splice_state_e nstate;
    framer_pkg::stream_beat_t  in_beat;
    framer_pkg::stream_beat_t  store_beat;
    framer_pkg::stream_beat_t  buf_beat;
    logic                      hdr_fire;
    logic                      body_fire;
    logic                      trl_fire;
    logic                      in_fire;
    logic                      out_fire;
    logic [1:0]                fill;
    logic [1:0]                next_fill;

    // Occupancy picks one state out of a part's group
    function automatic framer_pkg::splice_state_e pick_state(
        input framer_pkg::splice_state_e empty_s,
        input framer_pkg::splice_state_e full_s,
        input framer_pkg::splice_state_e buf_s,
        input logic [1:0]                fill_n
    );
        framer_pkg::splice_state_e res;
        case (fill_n)
            2'd0:    res = empty_s;
            2'd1:    res = full_s;
            default: res = buf_s;
        endcase
        return res;
    endfunction

    assign hdr_fire  = hdr_valid && hdr_ready;
    assign body_fire = body_valid && body_ready;
    assign trl_fire  = trl_valid && trl_ready;
    assign in_fire   = hdr_fire || body_fire || trl_fire;
    assign out_fire  = out_valid && out_ready;

    // At most one ready is high, so the mux needs no priority
    always_comb begin
        if (hdr_fire)
            in_beat = hdr_beat;
        else if (body_fire)
            in_beat = body_beat;
        else
            in_beat = trl_beat;
        store_beat.data = in_beat.data;
        // Only the trailer ends the output frame
        store_beat.last = trl_fire && in_beat.last;
    end

    always_comb begin
        case (state)
            framer_pkg::HEAD_FULL, framer_pkg::BODY_FULL,
            framer_pkg::END_FULL, framer_pkg::FINISH_FULL:
                fill = 2'd1;
            framer_pkg::HEAD_FULL_BUF, framer_pkg::BODY_FULL_BUF,
            framer_pkg::END_FULL_BUF, framer_pkg::FINISH_FULL_BUF:
                fill = 2'd2;
            default:
                fill = 2'd0;
        endcase
    end

    assign next_fill = fill + {1'b0, in_fire} - {1'b0, out_fire};

    always_comb begin
        case (state)
            framer_pkg::IDLE, framer_pkg::FINISH_FULL, framer_pkg::FINISH_FULL_BUF: begin
                if (hdr_fire && hdr_beat.last)
                    nstate = pick_state(framer_pkg::BODY_EMPTY, framer_pkg::BODY_FULL,
                                        framer_pkg::BODY_FULL_BUF, next_fill);
                else if (hdr_fire)
                    nstate = pick_state(framer_pkg::HEAD_EMPTY, framer_pkg::HEAD_FULL,
                                        framer_pkg::HEAD_FULL_BUF, next_fill);
                else
                    nstate = pick_state(framer_pkg::IDLE, framer_pkg::FINISH_FULL,
                                        framer_pkg::FINISH_FULL_BUF, next_fill);
            end
            framer_pkg::HEAD_EMPTY, framer_pkg::HEAD_FULL, framer_pkg::HEAD_FULL_BUF: begin
                if (in_fire && in_beat.last)
                    nstate = pick_state(framer_pkg::BODY_EMPTY, framer_pkg::BODY_FULL,
                                        framer_pkg::BODY_FULL_BUF, next_fill);
                else
                    nstate = pick_state(framer_pkg::HEAD_EMPTY, framer_pkg::HEAD_FULL,
                                        framer_pkg::HEAD_FULL_BUF, next_fill);
            end
            framer_pkg::BODY_EMPTY, framer_pkg::BODY_FULL, framer_pkg::BODY_FULL_BUF: begin
                if (in_fire && in_beat.last)
                    nstate = pick_state(framer_pkg::END_EMPTY, framer_pkg::END_FULL,
                                        framer_pkg::END_FULL_BUF, next_fill);
                else
                    nstate = pick_state(framer_pkg::BODY_EMPTY, framer_pkg::BODY_FULL,
                                        framer_pkg::BODY_FULL_BUF, next_fill);
            end
            default: begin
                if (in_fire && in_beat.last)
                    nstate = pick_state(framer_pkg::IDLE, framer_pkg::FINISH_FULL,
                                        framer_pkg::FINISH_FULL_BUF, next_fill);
                else
                    nstate = pick_state(framer_pkg::END_EMPTY, framer_pkg::END_FULL,
                                        framer_pkg::END_FULL_BUF, next_fill);
            end
        endcase
    end

    // Readies follow the next state, so a full skid buffer blocks input
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state      <= framer_pkg::IDLE;
            out_valid  <= 1'b0;
            hdr_ready  <= 1'b0;
            body_ready <= 1'b0;
            trl_ready  <= 1'b0;
        end else begin
            state      <= nstate;
            out_valid  <= (next_fill != 2'd0);
            hdr_ready  <= (nstate == framer_pkg::HEAD_EMPTY) ||
                          (nstate == framer_pkg::HEAD_FULL) ||
                          (trigger && (nstate == framer_pkg::IDLE ||
                                       nstate == framer_pkg::FINISH_FULL));
            body_ready <= (nstate == framer_pkg::BODY_EMPTY) ||
                          (nstate == framer_pkg::BODY_FULL);
            trl_ready  <= (nstate == framer_pkg::END_EMPTY) ||
                          (nstate == framer_pkg::END_FULL);
        end
    end

    always_ff @(posedge clock) begin
        if (fill == 2'd2 && out_fire)
            out_beat <= buf_beat;
        else if (in_fire && (!out_valid || out_fire))
            out_beat <= store_beat;
        // Stalled output, park the beat
        if (in_fire && out_valid && !out_fire)
            buf_beat <= store_beat;
    end

endmodule

/* hdl/trailer_builder.sv */
// ####################################################################
// Trailer builder: sums accepted payload words into one checksum beat
// ####################################################################
`timescale 1ns/1ps
module trailer_builder (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      body_fire,
    input  framer_pkg::stream_beat_t  body_beat,
    input  logic                      trl_ready,
    output logic                      trl_valid,
    output framer_pkg::stream_beat_t  trl_beat
);

    logic [31:0] sum;
    logic [31:0] sum_base;
    logic [31:0] sum_add;
    logic        trl_fire;

    assign trl_fire = trl_valid && trl_ready;

    // Sent trailer restarts the sum, even with a payload beat in the same cycle
    assign sum_base = trl_fire ? 32'd0 : sum;
    assign sum_add  = body_fire ? body_beat.data : 32'd0;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            sum <= '0;
        end else begin
            sum <= sum_base + sum_add;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            trl_valid <= 1'b0;
        end else begin
            if (body_fire && body_beat.last)
                trl_valid <= 1'b1;
            else if (trl_fire)
                trl_valid <= 1'b0;
        end
    end

    // Checksum is modulo 2^32, always the final beat
    always_comb begin
        trl_beat.data = sum;
        trl_beat.last = 1'b1;
    end

endmodule

/* hdl/header_builder.sv */
// ####################################################################
// Header builder: latches a frame descriptor and offers two header beats
// ####################################################################
`timescale 1ns/1ps
module header_builder (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      desc_strobe,
    input  framer_pkg::frame_desc_t   desc,
    input  logic                      hdr_ready,
    output logic                      hdr_valid,
    output framer_pkg::stream_beat_t  hdr_beat
);

    typedef enum logic [1:0] {
        HB_IDLE,
        HB_BEAT0,
        HB_BEAT1
    } hb_state_e;

    hb_state_e               state;
    framer_pkg::frame_desc_t desc_q;
    logic [31:0]             seq_num;
    logic                    hdr_fire;

    assign hdr_fire = hdr_valid && hdr_ready;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state   <= HB_IDLE;
            seq_num <= '0;
        end else begin
            case (state)
                HB_IDLE: begin
                    // Strobes while busy are dropped
                    if (desc_strobe)
                        state <= HB_BEAT0;
                end
                HB_BEAT0: begin
                    if (hdr_fire)
                        state <= HB_BEAT1;
                end
                default: begin
                    if (hdr_fire) begin
                        state   <= HB_IDLE;
                        seq_num <= seq_num + 32'd1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == HB_IDLE && desc_strobe)
            desc_q <= desc;
    end

    assign hdr_valid = (state != HB_IDLE);

    // Beat 0 is magic/tag/length, beat 1 the sequence number
    always_comb begin
        if (state == HB_BEAT1) begin
            hdr_beat.data = seq_num;
            hdr_beat.last = 1'b1;
        end else begin
            hdr_beat.data = {framer_pkg::HEADER_MAGIC, desc_q.tag, desc_q.length};
            hdr_beat.last = 1'b0;
        end
    end

endmodule

/* hdl/framer_pkg.sv */
// ####################################################################
// Packet framer shared types: stream beat, frame descriptor, splicer
// states and the header magic byte
// ####################################################################
package framer_pkg;

    // One beat of any data stream
    typedef struct packed {
        logic [31:0] data;
        logic        last;
    } stream_beat_t;

    typedef struct packed {
        logic [7:0]  tag;
        logic [15:0] length;
    } frame_desc_t;

    // Part of frame, then output register and skid buffer occupancy
    typedef enum logic [3:0] {
        IDLE,
        HEAD_EMPTY,
        HEAD_FULL,
        HEAD_FULL_BUF,
        BODY_EMPTY,
        BODY_FULL,
        BODY_FULL_BUF,
        END_EMPTY,
        END_FULL,
        END_FULL_BUF,
        FINISH_FULL,
        FINISH_FULL_BUF
    } splice_state_e;

    localparam logic [7:0] HEADER_MAGIC = 8'hA5;

endpackage
